// ==== verilog/bakraid_consts.svh ====
`ifndef BAKRAID_CONSTS_SVH
`define BAKRAID_CONSTS_SVH

// bus widths
`define DATA_W  16
`define ADDR_HI 23
`define RAM_AW  14
`define PRG_AW  20

// region match values on the byte address
`define ROM_TAG 3'h0   // bits 23..21, 0x000000-0x1FFFFF
`define RAM_TAG 9'h041 // bits 23..15, 0x208000-0x20FFFF
`define GCU_TAG 4'h4   // bits 23..20
`define IO_TAG  4'h5   // bits 23..20

// i/o byte offsets inside 0x5000xx
`define IO_IN         8'h00
`define IO_SYS_DSW    8'h02
`define IO_DSW        8'h04
`define IO_VIDEO      8'h06
`define IO_SND3       8'h10
`define IO_SND4       8'h12
`define IO_LATCH1     8'h14
`define IO_LATCH2     8'h16
`define IO_EEPROM_R   8'h18
`define IO_CLR_SNDIRQ 8'h1C
`define IO_EEPROM_W   8'h1E
`define IO_TEXT_DMA   8'h80
`define IO_PAL_DMA    8'h82
`define IO_OBJBANK    8'hC0 // whole 0xC0-0xCF slot range

// gcu register offsets, low nibble
`define GCU_WR_REG  4'h0
`define GCU_SEL_REG 4'h4
`define GCU_RAM_H   4'h8
`define GCU_RAM_L   4'hA
`define GCU_PTR     4'hC

// video status word
`define VS_HS_BIT 15
`define VS_VS_BIT 14
`define VS_FB_BIT 8

`endif

// ==== verilog/bakraid_pkg.sv ====
package bakraid_pkg;

    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_ROM,
        REGION_RAM,
        REGION_GCU,
        REGION_IO
    } bus_region_t;

    typedef enum logic [3:0] {
        PORT_NONE,
        PORT_INPUTS,
        PORT_SYS_DSW,
        PORT_DSW,
        PORT_VIDEO,
        PORT_SND3,
        PORT_SND4,
        PORT_LATCH1,
        PORT_LATCH2,
        PORT_EEPROM_R,
        PORT_CLR_SNDIRQ,
        PORT_EEPROM_W,
        PORT_TEXT_DMA,
        PORT_PAL_DMA,
        PORT_OBJBANK
    } io_port_t;

    typedef enum logic [2:0] {
        GCU_NOP,
        GCU_SELECT_REG,
        GCU_WRITE_REG,
        GCU_WRITE_RAM,
        GCU_READ_RAM_H,
        GCU_READ_RAM_L,
        GCU_SET_RAM_PTR,
        GCU_OBJBANK_WR
    } gcu_op_t;

endpackage

// ==== verilog/bus_decoder.sv ====
`timescale 1ns/1ps
`include "bakraid_consts.svh"

module bus_decoder (
    input  logic                      CLK96,
    input  logic                      RESET96,
    input  logic [`ADDR_HI:1]         cpu_addr,
    input  logic                      as_n,
    input  logic                      uds_n,
    input  logic                      lds_n,
    input  logic                      rw,
    output bakraid_pkg::bus_region_t  region,
    output bakraid_pkg::io_port_t     io_port,
    output logic [3:0]                gcu_offset,
    output logic                      cpu_prg_cs,
    output logic [`PRG_AW-1:0]        cpu_prg_addr
);
    import bakraid_pkg::*;

    logic [`ADDR_HI:0] addr_8; // byte address, matches the memory map
    bus_region_t       region_d;
    io_port_t          port_d;

    assign addr_8 = {cpu_addr, 1'b0};

    always_comb begin
        region_d = REGION_NONE;
        if (addr_8[`ADDR_HI:21] == `ROM_TAG)
            region_d = REGION_ROM;
        else if (addr_8[`ADDR_HI:15] == `RAM_TAG)
            region_d = REGION_RAM;
        else if (addr_8[`ADDR_HI:20] == `GCU_TAG)
            region_d = REGION_GCU;
        else if (addr_8[`ADDR_HI:20] == `IO_TAG)
            region_d = REGION_IO;
    end

    always_comb begin
        port_d = PORT_NONE;
        if (region_d == REGION_IO) begin
            case (addr_8[7:0])
                `IO_IN:         port_d = PORT_INPUTS;
                `IO_SYS_DSW:    port_d = PORT_SYS_DSW;
                `IO_DSW:        port_d = PORT_DSW;
                `IO_VIDEO:      port_d = PORT_VIDEO;
                `IO_SND3:       port_d = PORT_SND3;
                `IO_SND4:       port_d = PORT_SND4;
                `IO_LATCH1:     if (!rw && !lds_n) port_d = PORT_LATCH1; // byte write only
                `IO_LATCH2:     if (!rw && !lds_n) port_d = PORT_LATCH2;
                `IO_EEPROM_R:   if (rw) port_d = PORT_EEPROM_R;
                `IO_CLR_SNDIRQ: port_d = PORT_CLR_SNDIRQ;
                `IO_EEPROM_W:   if (!rw) port_d = PORT_EEPROM_W;
                `IO_TEXT_DMA:   port_d = PORT_TEXT_DMA;
                `IO_PAL_DMA:    port_d = PORT_PAL_DMA;
                default: begin
                    // object bank decodes on the high nibble only
                    if ((addr_8[7:0] & 8'hF0) == `IO_OBJBANK)
                        port_d = PORT_OBJBANK;
                end
            endcase
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            region       <= REGION_NONE;
            io_port      <= PORT_NONE;
            gcu_offset   <= '0;
            cpu_prg_addr <= '0;
        end else if (!as_n) begin
            region       <= region_d;
            io_port      <= port_d;
            gcu_offset   <= addr_8[3:0];
            cpu_prg_addr <= cpu_addr[`PRG_AW:1];
        end else begin
            region  <= REGION_NONE; // rom address holds between cycles
            io_port <= PORT_NONE;
        end
    end

    assign cpu_prg_cs = (region == REGION_ROM) && !(uds_n && lds_n);

endmodule

// ==== verilog/work_ram.sv ====
`timescale 1ns/1ps
`include "bakraid_consts.svh"

module work_ram (
    input  logic                CLK96,
    input  logic [`RAM_AW-1:0]  ram_addr,
    input  logic [`DATA_W-1:0]  wr_data,
    input  logic                we_hi,
    input  logic                we_lo,
    output logic [`DATA_W-1:0]  ram_q
);

    // one array per byte lane
    logic [7:0] mem_hi [0:(1 << `RAM_AW)-1];
    logic [7:0] mem_lo [0:(1 << `RAM_AW)-1];

    always_ff @(posedge CLK96) begin
        if (we_hi)
            mem_hi[ram_addr] <= wr_data[15:8];
        if (we_lo)
            mem_lo[ram_addr] <= wr_data[7:0];
        ram_q <= {mem_hi[ram_addr], mem_lo[ram_addr]}; // old data on a write cycle
    end

endmodule

// ==== verilog/read_data_mux.sv ====
`timescale 1ns/1ps
`include "bakraid_consts.svh"

module read_data_mux (
    input  logic                      CLK96,
    input  logic                      RESET96,
    input  bakraid_pkg::bus_region_t  region,
    input  bakraid_pkg::io_port_t     io_port,
    input  logic                      rw,
    input  logic [`DATA_W-1:0]        ram_q,
    input  logic [`DATA_W-1:0]        gp9001_dout,
    input  logic [`DATA_W-1:0]        cpu_prg_data,
    input  logic [9:0]                joystick1,
    input  logic [9:0]                joystick2,
    input  logic [1:0]                start_button,
    input  logic [1:0]                coin_input,
    input  logic                      service,
    input  logic                      dip_test,
    input  logic [7:0]                dipsw_a,
    input  logic [7:0]                dipsw_b,
    input  logic [7:0]                dipsw_c,
    input  logic [8:0]                v,
    input  logic                      hsync,
    input  logic                      vsync,
    input  logic                      fblank,
    input  logic [7:0]                soundlatch3,
    input  logic [7:0]                soundlatch4,
    input  logic                      eeprom_sdo,
    input  logic                      z80_bus_request,
    output logic [`DATA_W-1:0]        cpu_din
);
    import bakraid_pkg::*;

    logic [7:0]         p1_byte;
    logic [7:0]         p2_byte;
    logic [7:0]         sys_byte;
    logic [`DATA_W-1:0] video_word;
    logic [`DATA_W-1:0] din_next;

    // frame inputs are active low, the game wants active high
    assign p1_byte = {1'b0, ~joystick1[6], ~joystick1[5], ~joystick1[4],
                      ~joystick1[0], ~joystick1[1], ~joystick1[2], ~joystick1[3]};
    assign p2_byte = {1'b0, ~joystick2[6], ~joystick2[5], ~joystick2[4],
                      ~joystick2[0], ~joystick2[1], ~joystick2[2], ~joystick2[3]};
    assign sys_byte = {1'b0, ~start_button[1], ~start_button[0], ~coin_input[1],
                       ~coin_input[0], ~dip_test, 1'b0, ~service};

    always_comb begin
        video_word = {8'hFF, v[8] ? 8'hFF : v[7:0]}; // lines past 255 read as FF
        if (!hsync)
            video_word[`VS_HS_BIT] = 1'b0;
        if (!vsync)
            video_word[`VS_VS_BIT] = 1'b0;
        if (!fblank)
            video_word[`VS_FB_BIT] = 1'b0;
    end

    always_comb begin
        din_next = '0;
        case (region)
            REGION_ROM: din_next = cpu_prg_data;
            REGION_RAM: din_next = ram_q;
            REGION_GCU: if (rw) din_next = gp9001_dout;
            REGION_IO: begin
                case (io_port)
                    PORT_INPUTS:   din_next = {p2_byte, p1_byte};
                    PORT_SYS_DSW:  din_next = {dipsw_c, sys_byte};
                    PORT_DSW:      din_next = {dipsw_b, dipsw_a};
                    PORT_VIDEO:    din_next = video_word;
                    PORT_SND3:     din_next = {8'h00, soundlatch3};
                    PORT_SND4:     din_next = {8'h00, soundlatch4};
                    PORT_EEPROM_R: din_next = {11'h0, eeprom_sdo, 3'b000, z80_bus_request};
                    default:       din_next = '0; // write-only ports
                endcase
            end
            default: din_next = '0;
        endcase
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96)
            cpu_din <= '0;
        else
            cpu_din <= din_next;
    end

endmodule

// ==== verilog/io_control_regs.sv ====
`timescale 1ns/1ps
`include "bakraid_consts.svh"

module io_control_regs (
    input  logic                      CLK96,
    input  logic                      RESET96,
    input  logic                      cen16,
    input  bakraid_pkg::bus_region_t  region,
    input  bakraid_pkg::io_port_t     io_port,
    input  logic [3:0]                gcu_offset,
    input  logic                      rw,
    input  logic                      lds_n,
    input  logic [`DATA_W-1:0]        cpu_dout,
    input  logic                      snd_irq,
    input  logic                      gp9001_ack,
    input  logic                      tvramctl_busy,
    output logic [7:0]                soundlatch,
    output logic [7:0]                soundlatch2,
    output logic                      nmi,
    output logic                      ipl1_n,
    output logic                      gcu_select_reg,
    output logic                      gcu_write_reg,
    output logic                      gcu_write_ram,
    output logic                      gcu_read_ram_h,
    output logic                      gcu_read_ram_l,
    output logic                      gcu_set_ram_ptr,
    output logic                      gcu_objectbank_wr,
    output logic [2:0]                objectbank_slot,
    output logic                      textdata_dma_w,
    output logic                      pal_text_dma_w,
    output logic                      eeprom_sclk,
    output logic                      eeprom_sdi,
    output logic                      eeprom_scs,
    output logic                      z80_bus_request
);
    import bakraid_pkg::*;

    gcu_op_t gcu_op;
    logic    snd_irq_d;
    logic    snd_irq_flag;

    // which gcu strobe this access asks for
    always_comb begin
        gcu_op = GCU_NOP;
        if (io_port == PORT_OBJBANK) begin
            gcu_op = GCU_OBJBANK_WR;
        end else if (region == REGION_GCU && rw) begin
            case (gcu_offset)
                `GCU_RAM_H: gcu_op = GCU_READ_RAM_H;
                `GCU_RAM_L: gcu_op = GCU_READ_RAM_L;
                default:    gcu_op = GCU_NOP;
            endcase
        end else if (region == REGION_GCU) begin
            case (gcu_offset)
                `GCU_WR_REG:           gcu_op = GCU_WRITE_REG;
                `GCU_SEL_REG:          gcu_op = GCU_SELECT_REG;
                `GCU_RAM_H, `GCU_RAM_L: gcu_op = GCU_WRITE_RAM;
                `GCU_PTR:              gcu_op = GCU_SET_RAM_PTR;
                default:               gcu_op = GCU_NOP;
            endcase
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            soundlatch        <= '0;
            soundlatch2       <= '0;
            nmi               <= 1'b0;
            gcu_select_reg    <= 1'b0;
            gcu_write_reg     <= 1'b0;
            gcu_write_ram     <= 1'b0;
            gcu_read_ram_h    <= 1'b0;
            gcu_read_ram_l    <= 1'b0;
            gcu_set_ram_ptr   <= 1'b0;
            gcu_objectbank_wr <= 1'b0;
            objectbank_slot   <= '0;
            textdata_dma_w    <= 1'b0;
            pal_text_dma_w    <= 1'b0;
        end else begin
            if (io_port == PORT_LATCH1) begin
                soundlatch <= cpu_dout[7:0];
                nmi        <= 1'b1; // wakes the z80
            end else if (io_port == PORT_LATCH2) begin
                soundlatch2 <= cpu_dout[7:0];
                nmi         <= 1'b1;
            end else if (io_port == PORT_TEXT_DMA) begin
                textdata_dma_w <= 1'b1;
            end else if (io_port == PORT_PAL_DMA) begin
                pal_text_dma_w <= 1'b1;
            end else if (io_port == PORT_OBJBANK || region == REGION_GCU) begin
                // unmatched gcu offsets still count as busy cycles
                case (gcu_op)
                    GCU_OBJBANK_WR: begin
                        objectbank_slot   <= gcu_offset[3:1];
                        gcu_objectbank_wr <= 1'b1;
                    end
                    GCU_READ_RAM_H:  gcu_read_ram_h  <= 1'b1;
                    GCU_READ_RAM_L:  gcu_read_ram_l  <= 1'b1;
                    GCU_WRITE_REG:   gcu_write_reg   <= 1'b1;
                    GCU_SELECT_REG:  gcu_select_reg  <= 1'b1;
                    GCU_WRITE_RAM:   gcu_write_ram   <= 1'b1;
                    GCU_SET_RAM_PTR: gcu_set_ram_ptr <= 1'b1;
                    default: ;
                endcase
            end else begin
                nmi <= 1'b0;
                if (!tvramctl_busy) begin
                    textdata_dma_w <= 1'b0;
                    pal_text_dma_w <= 1'b0;
                end
                if (gp9001_ack) begin // strobes held until the gcu takes them
                    gcu_select_reg    <= 1'b0;
                    gcu_write_reg     <= 1'b0;
                    gcu_write_ram     <= 1'b0;
                    gcu_read_ram_h    <= 1'b0;
                    gcu_read_ram_l    <= 1'b0;
                    gcu_set_ram_ptr   <= 1'b0;
                    gcu_objectbank_wr <= 1'b0;
                end
            end
        end
    end

    // eeprom pins and z80 bus request, low byte write on the cpu phase
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            z80_bus_request <= 1'b0;
            eeprom_sclk     <= 1'b0;
            eeprom_sdi      <= 1'b0;
            eeprom_scs      <= 1'b0;
        end else if (cen16 && io_port == PORT_EEPROM_W && !lds_n) begin
            z80_bus_request <= cpu_dout[4];
            eeprom_sclk     <= cpu_dout[3];
            eeprom_sdi      <= cpu_dout[2];
            eeprom_scs      <= cpu_dout[0];
        end
    end

    // sound irq, rising edge sets, clear port wins
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            snd_irq_d    <= 1'b0;
            snd_irq_flag <= 1'b0;
        end else begin
            snd_irq_d <= snd_irq;
            if (io_port == PORT_CLR_SNDIRQ)
                snd_irq_flag <= 1'b0;
            else if (snd_irq && !snd_irq_d)
                snd_irq_flag <= 1'b1;
        end
    end

    assign ipl1_n = ~snd_irq_flag;

endmodule

// ==== verilog/bakraid_main_bus.sv ====
`timescale 1ns/1ps
`include "bakraid_consts.svh"

module bakraid_main_bus (
    input  logic                CLK96,
    input  logic                RESET96,
    input  logic                cen16,
    // 68000 bus
    input  logic [`ADDR_HI:1]   cpu_addr,
    input  logic [`DATA_W-1:0]  cpu_dout,
    input  logic                as_n,
    input  logic                uds_n,
    input  logic                lds_n,
    input  logic                rw,
    output logic [`DATA_W-1:0]  cpu_din,
    output logic                ipl1_n,
    // program rom controller
    output logic                cpu_prg_cs,
    output logic [`PRG_AW-1:0]  cpu_prg_addr,
    input  logic [`DATA_W-1:0]  cpu_prg_data,
    // cabinet
    input  logic [9:0]          joystick1,
    input  logic [9:0]          joystick2,
    input  logic [1:0]          start_button,
    input  logic [1:0]          coin_input,
    input  logic                service,
    input  logic                dip_test,
    input  logic [7:0]          dipsw_a,
    input  logic [7:0]          dipsw_b,
    input  logic [7:0]          dipsw_c,
    // video timing
    input  logic [8:0]          v,
    input  logic                hsync,
    input  logic                vsync,
    input  logic                fblank,
    // gcu
    input  logic [`DATA_W-1:0]  gp9001_dout,
    input  logic                gp9001_ack,
    output logic                gcu_select_reg,
    output logic                gcu_write_reg,
    output logic                gcu_write_ram,
    output logic                gcu_read_ram_h,
    output logic                gcu_read_ram_l,
    output logic                gcu_set_ram_ptr,
    output logic                gcu_objectbank_wr,
    output logic [2:0]          objectbank_slot,
    // text dma
    input  logic                tvramctl_busy,
    output logic                textdata_dma_w,
    output logic                pal_text_dma_w,
    // sound cpu
    input  logic [7:0]          soundlatch3,
    input  logic [7:0]          soundlatch4,
    input  logic                snd_irq,
    output logic [7:0]          soundlatch,
    output logic [7:0]          soundlatch2,
    output logic                nmi,
    output logic                z80_bus_request,
    // serial eeprom
    input  logic                eeprom_sdo,
    output logic                eeprom_sclk,
    output logic                eeprom_sdi,
    output logic                eeprom_scs
);
    import bakraid_pkg::*;

    bus_region_t        region;
    io_port_t           io_port;
    logic [3:0]         gcu_offset;
    logic [`DATA_W-1:0] ram_q;
    logic               ram_we_hi;
    logic               ram_we_lo;

    assign ram_we_hi = (region == REGION_RAM) && !rw && !uds_n;
    assign ram_we_lo = (region == REGION_RAM) && !rw && !lds_n;

    bus_decoder u_decoder (.*);

    // raw bus address, so the read word is ready for the mux edge
    work_ram u_work_ram (
        .CLK96    (CLK96),
        .ram_addr (cpu_addr[`RAM_AW:1]),
        .wr_data  (cpu_dout),
        .we_hi    (ram_we_hi),
        .we_lo    (ram_we_lo),
        .ram_q    (ram_q)
    );

    read_data_mux u_read_mux (.*);

    io_control_regs u_io_regs (.*);

endmodule

// ==== test/tb_bakraid_main_bus.sv ====
`timescale 1ns/1ps

module tb_bakraid_main_bus;

    localparam int CLK_PERIOD = 8;
    // reset, ram, inputs, sound, gcu, eeprom/dma, rom
    localparam int TEST_CYCLES = 10 + 70 + 130 + 40 + 90 + 50 + 15;

    // dut inputs
    logic        CLK96;
    logic        RESET96;
    logic        cen16;
    logic [23:1] cpu_addr;
    logic [15:0] cpu_dout;
    logic        as_n;
    logic        uds_n;
    logic        lds_n;
    logic        rw;
    logic [15:0] cpu_prg_data;
    logic [9:0]  joystick1;
    logic [9:0]  joystick2;
    logic [1:0]  start_button;
    logic [1:0]  coin_input;
    logic        service;
    logic        dip_test;
    logic [7:0]  dipsw_a;
    logic [7:0]  dipsw_b;
    logic [7:0]  dipsw_c;
    logic [8:0]  v;
    logic        hsync;
    logic        vsync;
    logic        fblank;
    logic [15:0] gp9001_dout;
    logic        gp9001_ack;
    logic        tvramctl_busy;
    logic [7:0]  soundlatch3;
    logic [7:0]  soundlatch4;
    logic        snd_irq;
    logic        eeprom_sdo;

    // dut outputs
    logic [15:0] cpu_din;
    logic        ipl1_n;
    logic        cpu_prg_cs;
    logic [19:0] cpu_prg_addr;
    logic        gcu_select_reg;
    logic        gcu_write_reg;
    logic        gcu_write_ram;
    logic        gcu_read_ram_h;
    logic        gcu_read_ram_l;
    logic        gcu_set_ram_ptr;
    logic        gcu_objectbank_wr;
    logic [2:0]  objectbank_slot;
    logic        textdata_dma_w;
    logic        pal_text_dma_w;
    logic [7:0]  soundlatch;
    logic [7:0]  soundlatch2;
    logic        nmi;
    logic        z80_bus_request;
    logic        eeprom_sclk;
    logic        eeprom_sdi;
    logic        eeprom_scs;

    logic [6:0]  gcu_strobes;
    logic [31:0] rng_state;
    int          error_count;

    assign gcu_strobes = {gcu_select_reg, gcu_write_reg, gcu_write_ram, gcu_read_ram_h,
                          gcu_read_ram_l, gcu_set_ram_ptr, gcu_objectbank_wr};

    bakraid_main_bus uut (.*);

    initial begin
        CLK96 = 1'b0;
        forever #(CLK_PERIOD / 2) CLK96 = ~CLK96;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // active high player byte from the raw frame bits
    function automatic logic [7:0] player_byte(input logic [9:0] j);
        return {1'b0, ~j[6], ~j[5], ~j[4], ~j[0], ~j[1], ~j[2], ~j[3]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            error_count++;
            $display("mismatch %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLK96);
        #1;
    endtask

    task automatic start_access(input logic [23:0] byte_addr, input logic read,
                                input logic [15:0] data, input logic udsn, input logic ldsn);
        cpu_addr = byte_addr[23:1];
        cpu_dout = data;
        rw       = read;
        uds_n    = udsn;
        lds_n    = ldsn;
        as_n     = 1'b0;
    endtask

    task automatic end_access();
        as_n  = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
    endtask

    task automatic bus_read(input logic [23:0] byte_addr, input logic [15:0] exp,
                            input string name);
        start_access(byte_addr, 1'b1, 16'h0000, 1'b0, 1'b0);
        wait_cycles(4);
        check_value(name, cpu_din, exp);
        end_access();
        wait_cycles(1);
    endtask

    task automatic bus_write(input logic [23:0] byte_addr, input logic [15:0] data,
                             input logic udsn, input logic ldsn);
        start_access(byte_addr, 1'b0, data, udsn, ldsn);
        wait_cycles(4);
        end_access();
        wait_cycles(1); // one idle edge before the next access
        rw = 1'b1; // r/w goes high after the address strobe
    endtask

    task automatic reset_values();
        check_value("cpu_din", cpu_din, 16'h0000);
        check_value("nmi", nmi, 1'b0);
        check_value("ipl1_n", ipl1_n, 1'b1);
        check_value("gcu strobes", gcu_strobes, 7'h00);
        check_value("dma strobes", {textdata_dma_w, pal_text_dma_w}, 2'b00);
        check_value("soundlatch", soundlatch, 8'h00);
        check_value("soundlatch2", soundlatch2, 8'h00);
        check_value("eeprom pins", {eeprom_sclk, eeprom_sdi, eeprom_scs}, 3'b000);
        check_value("z80_bus_request", z80_bus_request, 1'b0);
    endtask

    task automatic ram_lane_writes();
        logic [13:0] idx [4];
        logic [15:0] expect_word [4];
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            r = next_random();
            idx[i] = {i[1:0], r[11:0]}; // distinct top bits keep the words apart
            expect_word[i] = r[31:16];
            bus_write({9'h041, idx[i], 1'b0}, expect_word[i], 1'b0, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            r = next_random();
            if (i[0]) begin
                bus_write({9'h041, idx[i], 1'b0}, r[15:0], 1'b0, 1'b1); // upper lane
                expect_word[i][15:8] = r[15:8];
            end else begin
                bus_write({9'h041, idx[i], 1'b0}, r[15:0], 1'b1, 1'b0); // lower lane
                expect_word[i][7:0] = r[7:0];
            end
        end
        for (int i = 0; i < 4; i++)
            bus_read({9'h041, idx[i], 1'b0}, expect_word[i], "cpu_din ram");
    endtask

    task automatic input_port_formats();
        logic [31:0] r;
        logic [15:0] exp_video;
        for (int i = 0; i < 4; i++) begin
            r = next_random();
            joystick1    = r[9:0];
            joystick2    = r[19:10];
            start_button = r[21:20];
            coin_input   = r[23:22];
            service      = r[24];
            dip_test     = r[25];
            hsync        = r[26];
            vsync        = r[27];
            fblank       = r[28];
            r = next_random();
            dipsw_a = r[7:0];
            dipsw_b = r[15:8];
            dipsw_c = r[23:16];
            v       = {i[0], r[31:24]}; // odd passes sit past line 255
            r = next_random();
            soundlatch3 = r[7:0];
            soundlatch4 = r[15:8];

            exp_video[15:8] = 8'hFF;
            if (!hsync)
                exp_video[15] = 1'b0;
            if (!vsync)
                exp_video[14] = 1'b0;
            if (!fblank)
                exp_video[8] = 1'b0;
            exp_video[7:0] = (v < 9'd256) ? v[7:0] : 8'hFF;

            bus_read(24'h500000, {player_byte(joystick2), player_byte(joystick1)},
                     "cpu_din inputs");
            bus_read(24'h500002, {dipsw_c, 1'b0, ~start_button[1], ~start_button[0],
                     ~coin_input[1], ~coin_input[0], ~dip_test, 1'b0, ~service},
                     "cpu_din system");
            bus_read(24'h500004, {dipsw_b, dipsw_a}, "cpu_din dsw");
            bus_read(24'h500006, exp_video, "cpu_din video");
            bus_read(24'h500010, {8'h00, soundlatch3}, "cpu_din soundlatch3");
            bus_read(24'h500012, {8'h00, soundlatch4}, "cpu_din soundlatch4");
        end
    endtask

    task automatic sound_latch_and_irq();
        logic [31:0] r;
        r = next_random();
        bus_write(24'h500014, r[15:0], 1'b1, 1'b0);
        check_value("soundlatch", soundlatch, r[7:0]);
        check_value("nmi", nmi, 1'b1);
        wait_cycles(2);
        check_value("nmi", nmi, 1'b0);
        bus_write(24'h500016, r[31:16], 1'b1, 1'b0);
        check_value("soundlatch2", soundlatch2, r[23:16]);
        check_value("soundlatch", soundlatch, r[7:0]);
        check_value("nmi", nmi, 1'b1);
        wait_cycles(2);
        check_value("nmi", nmi, 1'b0);

        check_value("ipl1_n", ipl1_n, 1'b1);
        snd_irq = 1'b1;
        wait_cycles(2);
        check_value("ipl1_n", ipl1_n, 1'b0);
        snd_irq = 1'b0;
        wait_cycles(3);
        check_value("ipl1_n", ipl1_n, 1'b0); // flag held after the source drops
        bus_write(24'h50001C, 16'h0000, 1'b0, 1'b0);
        check_value("ipl1_n", ipl1_n, 1'b1);
    endtask

    task automatic check_gcu_strobe(input logic [23:0] byte_addr, input logic is_read,
                                    input logic [6:0] exp_strobes);
        logic [31:0] r;
        r = next_random();
        if (is_read) begin
            gp9001_dout = r[31:16];
            bus_read(byte_addr, r[31:16], "cpu_din gcu");
        end else begin
            bus_write(byte_addr, r[15:0], 1'b0, 1'b0);
        end
        check_value("gcu strobes", gcu_strobes, exp_strobes);
        wait_cycles(3);
        check_value("gcu strobes held", gcu_strobes, exp_strobes);
        gp9001_ack = 1'b1;
        wait_cycles(2);
        check_value("gcu strobes after ack", gcu_strobes, 7'h00);
        gp9001_ack = 1'b0;
    endtask

    task automatic gcu_strobe_sequence();
        // bits run select, write_reg, write_ram, read_h, read_l, ptr, objbank
        check_gcu_strobe(24'h400000, 1'b0, 7'b0100000);
        check_gcu_strobe(24'h400004, 1'b0, 7'b1000000);
        check_gcu_strobe(24'h400008, 1'b0, 7'b0010000);
        check_gcu_strobe(24'h40000A, 1'b0, 7'b0010000);
        check_gcu_strobe(24'h40000C, 1'b0, 7'b0000010);
        check_gcu_strobe(24'h400008, 1'b1, 7'b0001000);
        check_gcu_strobe(24'h40000A, 1'b1, 7'b0000100);
        check_gcu_strobe(24'h5000C6, 1'b0, 7'b0000001);
        check_value("objectbank_slot", objectbank_slot, 3'd3);
    endtask

    task automatic eeprom_and_dma();
        logic [31:0] r;
        cen16 = 1'b0;
        bus_write(24'h50001E, 16'h001D, 1'b1, 1'b0); // no cpu phase so nothing loads
        check_value("eeprom bits", {z80_bus_request, eeprom_sclk, eeprom_sdi, eeprom_scs},
                    4'b0000);
        cen16 = 1'b1;
        bus_write(24'h50001E, 16'h001D, 1'b1, 1'b0);
        check_value("eeprom bits", {z80_bus_request, eeprom_sclk, eeprom_sdi, eeprom_scs},
                    4'b1111);
        r = next_random();
        bus_write(24'h50001E, r[15:0], 1'b1, 1'b0);
        cen16 = 1'b0;
        check_value("eeprom bits", {z80_bus_request, eeprom_sclk, eeprom_sdi, eeprom_scs},
                    {r[4], r[3], r[2], r[0]});
        eeprom_sdo = 1'b1;
        bus_read(24'h500018, {11'h000, 1'b1, 3'b000, r[4]}, "cpu_din eeprom");
        eeprom_sdo = 1'b0;
        bus_read(24'h500018, {11'h000, 1'b0, 3'b000, r[4]}, "cpu_din eeprom");

        tvramctl_busy = 1'b1;
        bus_write(24'h500080, 16'h0000, 1'b0, 1'b0);
        check_value("dma strobes", {textdata_dma_w, pal_text_dma_w}, 2'b10);
        wait_cycles(3);
        check_value("dma strobes busy", {textdata_dma_w, pal_text_dma_w}, 2'b10);
        tvramctl_busy = 1'b0;
        wait_cycles(2);
        check_value("dma strobes", {textdata_dma_w, pal_text_dma_w}, 2'b00);
        tvramctl_busy = 1'b1;
        bus_write(24'h500082, 16'h0000, 1'b0, 1'b0);
        check_value("dma strobes", {textdata_dma_w, pal_text_dma_w}, 2'b01);
        wait_cycles(3);
        check_value("dma strobes busy", {textdata_dma_w, pal_text_dma_w}, 2'b01);
        tvramctl_busy = 1'b0;
        wait_cycles(2);
        check_value("dma strobes", {textdata_dma_w, pal_text_dma_w}, 2'b00);
    endtask

    task automatic rom_and_unmapped_reads();
        logic [31:0] r;
        logic [23:0] addr;
        r = next_random();
        addr = {3'b000, r[20:1], 1'b0};
        r = next_random();
        cpu_prg_data = r[15:0];
        start_access(addr, 1'b1, 16'h0000, 1'b0, 1'b0);
        wait_cycles(4);
        check_value("cpu_prg_cs", cpu_prg_cs, 1'b1);
        check_value("cpu_prg_addr", cpu_prg_addr, addr[20:1]);
        check_value("cpu_din rom", cpu_din, r[15:0]);
        end_access();
        wait_cycles(1);
        check_value("cpu_prg_cs", cpu_prg_cs, 1'b0);
        gp9001_dout = 16'hA5A5; // nonzero sources that must not leak through
        bus_read(24'h300000, 16'h0000, "cpu_din unmapped");
    endtask

    initial begin
        rng_state     = 32'hde59;
        error_count   = 0;
        RESET96       = 1'b1;
        cen16         = 1'b0;
        cpu_addr      = '0;
        cpu_dout      = '0;
        as_n          = 1'b1;
        uds_n         = 1'b1;
        lds_n         = 1'b1;
        rw            = 1'b1;
        cpu_prg_data  = '0;
        joystick1     = '1;
        joystick2     = '1;
        start_button  = '1;
        coin_input    = '1;
        service       = 1'b1;
        dip_test      = 1'b1;
        dipsw_a       = '0;
        dipsw_b       = '0;
        dipsw_c       = '0;
        v             = '0;
        hsync         = 1'b1;
        vsync         = 1'b1;
        fblank        = 1'b1;
        gp9001_dout   = '0;
        gp9001_ack    = 1'b0;
        tvramctl_busy = 1'b0;
        soundlatch3   = '0;
        soundlatch4   = '0;
        snd_irq       = 1'b0;
        eeprom_sdo    = 1'b0;

        repeat (3) @(posedge CLK96);
        #1;
        RESET96 = 1'b0;
        wait_cycles(1);

        reset_values();
        ram_lane_writes();
        input_port_formats();
        sound_latch_and_irq();
        gcu_strobe_sequence();
        eeprom_and_dma();
        rom_and_unmapped_reads();

        $display("tests done, %0d errors", error_count);
        if (error_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // watchdog at twice the expected run length
    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        error_count++;
        $display("timeout: tests still running after %0d cycles", TEST_CYCLES * 2);
        $display("stopped early, %0d errors", error_count);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== bakraid_main_bus.f ====
+incdir+verilog
verilog/bakraid_pkg.sv
verilog/bus_decoder.sv
verilog/work_ram.sv
verilog/read_data_mux.sv
verilog/io_control_regs.sv
verilog/bakraid_main_bus.sv
test/tb_bakraid_main_bus.sv
